// ==== src/mem_pkg.sv ====
package mem_pkg;

    // plain widths
    typedef logic [31:0] word_t;    // data or address word
    typedef logic [3:0]  byte_en_t; // bit n covers byte lane n
    typedef logic [5:0]  opcode_t;  // instr[31:26]

    // loads
    localparam opcode_t OP_LB  = 6'h20;
    localparam opcode_t OP_LH  = 6'h21;
    localparam opcode_t OP_LWL = 6'h22;
    localparam opcode_t OP_LW  = 6'h23;
    localparam opcode_t OP_LBU = 6'h24;
    localparam opcode_t OP_LHU = 6'h25;
    localparam opcode_t OP_LWR = 6'h26;

    // stores
    localparam opcode_t OP_SB  = 6'h28;
    localparam opcode_t OP_SH  = 6'h29;
    localparam opcode_t OP_SWL = 6'h2A;
    localparam opcode_t OP_SW  = 6'h2B;
    localparam opcode_t OP_SWR = 6'h2E;

    // linked pair
    localparam opcode_t OP_LL  = 6'h30;
    localparam opcode_t OP_SC  = 6'h38;

    // request presented in M and sampled every cycle
    typedef struct packed {
        word_t instr;    // full instruction word
        word_t addr;     // effective byte address
        word_t wdata;    // rt value to store
        word_t rt_value; // old rt for LWL/LWR
    } mem_req_t;

    // one pending RAM write
    typedef struct packed {
        logic     we;
        word_t    addr; // word aligned
        byte_en_t be;
        word_t    data; // already lane formatted
    } wr_port_t;

    // load state carried from M into M2
    typedef struct packed {
        opcode_t    opcode;
        logic [1:0] lane;     // byte offset of the access
        word_t      rt_value;
        logic       fwd_hit;  // W write hit the same word
        byte_en_t   fwd_be;
        word_t      fwd_data;
        logic       link_ok;  // link bit seen by SC
    } load_m2_t;

endpackage

// ==== src/mem_control.sv ====
`timescale 1ns/1ns

module mem_control (
    input  mem_pkg::mem_req_t req,
    input  logic              link,
    input  mem_pkg::load_m2_t m2,
    input  mem_pkg::word_t    mem_rdata,
    output mem_pkg::wr_port_t st_port,
    output logic              is_ll,
    output logic              is_sc,
    output mem_pkg::word_t    rdata,
    output logic              addr_error_store,
    output logic              addr_error_load
);

    mem_pkg::opcode_t opcode;
    logic [1:0]       lane;
    logic             word_al;   // addr[1:0] == 0
    logic             half_al;   // addr[0] == 0
    logic             op_store;
    mem_pkg::byte_en_t st_be;
    mem_pkg::word_t    st_data;
    logic             st_we;

    mem_pkg::word_t   fwd_mask;
    mem_pkg::word_t   merged;    // RAM word with W bytes patched in
    mem_pkg::word_t   lane_data; // merged shifted down to the lane

    // expand byte enables to a bit mask
    function automatic mem_pkg::word_t byte_mask(input mem_pkg::byte_en_t be);
        mem_pkg::word_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

    // M stage decode
    assign opcode  = req.instr[31:26];
    assign lane    = req.addr[1:0];
    assign word_al = (lane == 2'b00);
    assign half_al = ~lane[0];

    assign op_store = (opcode == mem_pkg::OP_SW)  || (opcode == mem_pkg::OP_SH)
                   || (opcode == mem_pkg::OP_SB)  || (opcode == mem_pkg::OP_SWL)
                   || (opcode == mem_pkg::OP_SWR) || (opcode == mem_pkg::OP_SC);

    assign addr_error_store = ((opcode == mem_pkg::OP_SW) && !word_al)
                           || ((opcode == mem_pkg::OP_SC) && !word_al)
                           || ((opcode == mem_pkg::OP_SH) && !half_al);

    assign addr_error_load = ((opcode == mem_pkg::OP_LW) && !word_al)
                          || ((opcode == mem_pkg::OP_LL) && !word_al)
                          || ((opcode == mem_pkg::OP_LH) && !half_al)
                          || ((opcode == mem_pkg::OP_LHU) && !half_al);

    assign is_ll = (opcode == mem_pkg::OP_LL) && word_al;
    assign is_sc = (opcode == mem_pkg::OP_SC) && word_al;

    // byte enables and lane-replicated write data
    always_comb begin
        st_be   = '0;
        st_data = '0;
        case (opcode)
            mem_pkg::OP_SW, mem_pkg::OP_SC: begin
                st_be   = 4'b1111;
                st_data = req.wdata;
            end
            mem_pkg::OP_SH: begin
                st_be   = lane[1] ? 4'b1100 : 4'b0011;
                st_data = {2{req.wdata[15:0]}};
            end
            mem_pkg::OP_SB: begin
                st_be   = 4'b0001 << lane;
                st_data = {4{req.wdata[7:0]}};
            end
            mem_pkg::OP_SWL: begin
                st_be   = 4'b1111 >> (~lane);          // 0001 0011 0111 1111
                st_data = req.wdata >> {~lane, 3'b000}; // msbs down to the lane
            end
            mem_pkg::OP_SWR: begin
                st_be   = 4'b1111 << lane;             // 1111 1110 1100 1000
                st_data = req.wdata << {lane, 3'b000};
            end
            default: ;
        endcase
    end

    // SC only writes while the link holds
    assign st_we = op_store && !addr_error_store
                && ((opcode != mem_pkg::OP_SC) || link);

    assign st_port = '{
        we:   st_we,
        addr: {req.addr[31:2], 2'b00},
        be:   st_be,
        data: st_data
    };

    // M2 forward merge of the write that hit the read edge
    assign fwd_mask  = m2.fwd_hit ? byte_mask(m2.fwd_be) : '0;
    assign merged    = (mem_rdata & ~fwd_mask) | (m2.fwd_data & fwd_mask);
    assign lane_data = merged >> {m2.lane, 3'b000};

    // misaligned accesses fall to zero here as well
    always_comb begin
        rdata = '0;
        case (m2.opcode)
            mem_pkg::OP_LW, mem_pkg::OP_LL: begin
                if (m2.lane == 2'b00) rdata = merged;
            end
            mem_pkg::OP_LH: begin
                if (!m2.lane[0]) rdata = {{16{lane_data[15]}}, lane_data[15:0]};
            end
            mem_pkg::OP_LHU: begin
                if (!m2.lane[0]) rdata = {16'b0, lane_data[15:0]};
            end
            mem_pkg::OP_LB:  rdata = {{24{lane_data[7]}}, lane_data[7:0]};
            mem_pkg::OP_LBU: rdata = {24'b0, lane_data[7:0]};
            mem_pkg::OP_LWL: begin
                case (m2.lane)
                    2'b00:   rdata = {merged[7:0],  m2.rt_value[23:0]};
                    2'b01:   rdata = {merged[15:0], m2.rt_value[15:0]};
                    2'b10:   rdata = {merged[23:0], m2.rt_value[7:0]};
                    default: rdata = merged;
                endcase
            end
            mem_pkg::OP_LWR: begin
                case (m2.lane)
                    2'b00:   rdata = merged;
                    2'b01:   rdata = {m2.rt_value[31:24], merged[31:8]};
                    2'b10:   rdata = {m2.rt_value[31:16], merged[31:16]};
                    default: rdata = {m2.rt_value[31:8],  merged[31:24]};
                endcase
            end
            mem_pkg::OP_SC: begin
                if (m2.lane == 2'b00) rdata = {31'b0, m2.link_ok}; // 1 when written
            end
            default: ;
        endcase
    end

    // checked once inputs have settled
    always_comb begin
        if (!$isunknown(req)) begin
            a_we_has_be: assert final (!st_port.we || (st_port.be != '0))
                else $error("store write with empty byte enable");
            a_one_error: assert final (!(addr_error_store && addr_error_load))
                else $error("store and load address error together");
        end
    end

endmodule

// ==== src/mem_pipe_regs.sv ====
`timescale 1ns/1ns

module mem_pipe_regs (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::mem_req_t req,
    input  mem_pkg::wr_port_t st_port,
    input  logic              is_ll,
    input  logic              is_sc,
    output mem_pkg::wr_port_t w_port,
    output logic              link,
    output mem_pkg::load_m2_t m2
);

    logic              fwd_hit;
    mem_pkg::load_m2_t m2_next;

    // the RAM returns old data when W writes the word being read
    assign fwd_hit = w_port.we && (w_port.addr[31:2] == req.addr[31:2]);

    assign m2_next = '{
        opcode:   req.instr[31:26],
        lane:     req.addr[1:0],
        rt_value: req.rt_value,
        fwd_hit:  fwd_hit,
        fwd_be:   w_port.be,
        fwd_data: w_port.data,
        link_ok:  link
    };

    // W write register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_port <= '0;
        end else begin
            w_port <= st_port;
        end
    end

    // M2 load record
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m2 <= '0;
        end else begin
            m2 <= m2_next;
        end
    end

    // LL/SC link
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            link <= 1'b0;
        end else if (is_sc) begin
            link <= 1'b0; // any aligned SC consumes it
        end else if (is_ll) begin
            link <= 1'b1;
        end
    end

    a_w_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        w_port.we |-> (w_port.addr[1:0] == 2'b00)
    ) else $error("W write to unaligned address");

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
    parameter int ram_words = 1024
) (
    input  logic              clk,
    input  mem_pkg::wr_port_t w_port,
    input  mem_pkg::word_t    raddr,
    output mem_pkg::word_t    mem_rdata
);

    localparam int idx_w = $clog2(ram_words);

    logic [3:0][7:0]  mem [ram_words];
    logic [idx_w-1:0] widx;
    logic [idx_w-1:0] ridx;

    // upper address bits ignored so addresses wrap
    assign widx = w_port.addr[idx_w+1:2];
    assign ridx = raddr[idx_w+1:2];

    // power-up contents zero
    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (w_port.we && w_port.be[b]) begin
                mem[widx][b] <= w_port.data[8*b +: 8];
            end
        end
        mem_rdata <= mem[ridx]; // old word on a same-edge write
    end

endmodule

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ns

module mem_stage_top #(
    parameter int ram_words = 1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::word_t    rdata,
    output logic              addr_error_store,
    output logic              addr_error_load
);

    mem_pkg::wr_port_t st_port;   // formatted store in M
    mem_pkg::wr_port_t w_port;    // store being written in W
    mem_pkg::load_m2_t m2;
    mem_pkg::word_t    mem_rdata;
    logic              link;
    logic              is_ll;
    logic              is_sc;

    mem_control i_mem_control (
        .req              (req),
        .link             (link),
        .m2               (m2),
        .mem_rdata        (mem_rdata),
        .st_port          (st_port),
        .is_ll            (is_ll),
        .is_sc            (is_sc),
        .rdata            (rdata),
        .addr_error_store (addr_error_store),
        .addr_error_load  (addr_error_load)
    );

    mem_pipe_regs i_mem_pipe_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .st_port (st_port),
        .is_ll   (is_ll),
        .is_sc   (is_sc),
        .w_port  (w_port),
        .link    (link),
        .m2      (m2)
    );

    // read at the end of M and written from W
    data_ram #(
        .ram_words (ram_words)
    ) i_data_ram (
        .clk       (clk),
        .w_port    (w_port),
        .raddr     (req.addr),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== test/tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage;

    localparam int n_directed   = 82;  // directed requests with the trailing nops
    localparam int n_random     = 400;
    localparam int reset_cycles = 5;
    localparam int cycle_limit  = reset_cycles + n_directed + n_random + 50;

    logic              clk;
    logic              arst_n;
    mem_pkg::mem_req_t req;
    mem_pkg::word_t    rdata;
    logic              addr_error_store;
    logic              addr_error_load;

    logic [7:0]     model_mem [256]; // 64 words kept as bytes
    logic           model_link;

    logic           es_q [$];        // expected flags, one per request
    logic           el_q [$];
    mem_pkg::word_t rd_q [$];
    mem_pkg::word_t rd_expect;
    logic           rd_pend;         // rdata of the previous request due now
    int             cycle_count;

    mem_stage_top #(
        .ram_words (64)
    ) i_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .req              (req),
        .rdata            (rdata),
        .addr_error_store (addr_error_store),
        .addr_error_load  (addr_error_load)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input mem_pkg::word_t got,
                               input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic void put_byte(input mem_pkg::word_t addr, input int lane,
                                     input logic [7:0] value);
        model_mem[int'(addr[7:2]) * 4 + lane] = value;
    endfunction

    function automatic logic [7:0] get_byte(input mem_pkg::word_t addr, input int lane);
        return model_mem[int'(addr[7:2]) * 4 + lane];
    endfunction

    function automatic logic store_error(input mem_pkg::opcode_t op,
                                         input mem_pkg::word_t addr);
        case (op)
            mem_pkg::OP_SW, mem_pkg::OP_SC: return addr[1:0] != 2'b00;
            mem_pkg::OP_SH:                 return addr[0];
            default:                        return 1'b0;
        endcase
    endfunction

    function automatic logic load_error(input mem_pkg::opcode_t op,
                                        input mem_pkg::word_t addr);
        case (op)
            mem_pkg::OP_LW, mem_pkg::OP_LL:  return addr[1:0] != 2'b00;
            mem_pkg::OP_LH, mem_pkg::OP_LHU: return addr[0];
            default:                         return 1'b0;
        endcase
    endfunction

    // result as the model memory stands before this request
    function automatic mem_pkg::word_t load_result(input mem_pkg::opcode_t op,
                                                   input mem_pkg::word_t addr,
                                                   input mem_pkg::word_t rt);
        mem_pkg::word_t w;
        mem_pkg::word_t r;
        int             k;
        k = int'(addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = get_byte(addr, i);
        end
        r = '0;
        if (store_error(op, addr) || load_error(op, addr)) begin
            return r;
        end
        case (op)
            mem_pkg::OP_LW, mem_pkg::OP_LL: r = w;
            mem_pkg::OP_LH:  r = {{16{w[8*k+15]}}, w[8*k +: 16]};
            mem_pkg::OP_LHU: r = {16'h0000, w[8*k +: 16]};
            mem_pkg::OP_LB:  r = {{24{w[8*k+7]}}, w[8*k +: 8]};
            mem_pkg::OP_LBU: r = {24'h000000, w[8*k +: 8]};
            mem_pkg::OP_LWL: begin
                r = rt;
                for (int i = 0; i <= k; i++) begin
                    r[8*(3-k+i) +: 8] = w[8*i +: 8]; // low bytes into the top of rt
                end
            end
            mem_pkg::OP_LWR: begin
                r = rt;
                for (int i = k; i < 4; i++) begin
                    r[8*(i-k) +: 8] = w[8*i +: 8];
                end
            end
            mem_pkg::OP_SC: r = {31'b0, model_link};
            default: ;
        endcase
        return r;
    endfunction

    function automatic void store_effect(input mem_pkg::opcode_t op,
                                         input mem_pkg::word_t addr,
                                         input mem_pkg::word_t wdata);
        int k;
        k = int'(addr[1:0]);
        if (store_error(op, addr) || load_error(op, addr)) begin
            return; // faulting access touches neither memory nor link
        end
        case (op)
            mem_pkg::OP_SW: begin
                for (int i = 0; i < 4; i++) put_byte(addr, i, wdata[8*i +: 8]);
            end
            mem_pkg::OP_SC: begin
                if (model_link) begin
                    for (int i = 0; i < 4; i++) put_byte(addr, i, wdata[8*i +: 8]);
                end
                model_link = 1'b0;
            end
            mem_pkg::OP_SH: begin
                put_byte(addr, k, wdata[7:0]);
                put_byte(addr, k + 1, wdata[15:8]);
            end
            mem_pkg::OP_SB: put_byte(addr, k, wdata[7:0]);
            mem_pkg::OP_SWL: begin
                for (int i = 0; i <= k; i++) put_byte(addr, i, wdata[8*(3-k+i) +: 8]);
            end
            mem_pkg::OP_SWR: begin
                for (int i = k; i < 4; i++) put_byte(addr, i, wdata[8*(i-k) +: 8]);
            end
            mem_pkg::OP_LL: model_link = 1'b1;
            default: ;
        endcase
    endfunction

    function automatic mem_pkg::opcode_t pick_op(input int n);
        case (n)
            0:  return mem_pkg::OP_LB;
            1:  return mem_pkg::OP_LH;
            2:  return mem_pkg::OP_LWL;
            3:  return mem_pkg::OP_LW;
            4:  return mem_pkg::OP_LBU;
            5:  return mem_pkg::OP_LHU;
            6:  return mem_pkg::OP_LWR;
            7:  return mem_pkg::OP_SB;
            8:  return mem_pkg::OP_SH;
            9:  return mem_pkg::OP_SWL;
            10: return mem_pkg::OP_SW;
            11: return mem_pkg::OP_SWR;
            12: return mem_pkg::OP_LL;
            13: return mem_pkg::OP_SC;
            14: return 6'h27;   // unused slot
            default: return 6'h0F; // lui, not a memory op
        endcase
    endfunction

    // one request per cycle with the model updated in program order
    task automatic issue(input mem_pkg::opcode_t op, input mem_pkg::word_t addr,
                         input mem_pkg::word_t wdata, input mem_pkg::word_t rt);
        mem_pkg::word_t junk;
        @(posedge clk);
        #2;
        junk         = $urandom;
        req.instr    = {op, junk[25:0]};
        req.addr     = addr;
        req.wdata    = wdata;
        req.rt_value = rt;
        es_q.push_back(store_error(op, addr));
        el_q.push_back(load_error(op, addr));
        rd_q.push_back(load_result(op, addr, rt));
        store_effect(op, addr, wdata);
    endtask

    // flags of this cycle's request and rdata of the one before
    always @(negedge clk) begin
        logic exp_es;
        logic exp_el;
        if (rd_pend) begin
            check_value("rdata", rdata, rd_expect);
        end
        rd_pend = 1'b0;
        if (es_q.size() != 0) begin
            exp_es = es_q.pop_front();
            exp_el = el_q.pop_front();
            check_value("addr_error_store", {31'b0, addr_error_store}, {31'b0, exp_es});
            check_value("addr_error_load", {31'b0, addr_error_load}, {31'b0, exp_el});
            rd_expect = rd_q.pop_front();
            rd_pend   = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        mem_pkg::opcode_t op;
        mem_pkg::word_t   addr;
        int               lane;
        void'($urandom(49338));
        clk         = 1'b0;
        arst_n      = 1'b0;
        req         = '0;
        rd_pend     = 1'b0;
        rd_expect   = '0;
        cycle_count = 0;
        model_link  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // sc straight after reset fails and then an ll/sc pair
        issue(mem_pkg::OP_SC, 28, 32'h00000077, 0);
        issue(mem_pkg::OP_LW, 28, 0, 0);
        issue(mem_pkg::OP_LL, 28, 0, 0);
        issue(mem_pkg::OP_SC, 28, 32'h13579BDF, 0);
        issue(mem_pkg::OP_SC, 28, 32'h24680ACE, 0); // link already consumed
        issue(mem_pkg::OP_LW, 28, 0, 0);

        // store widths and lanes, load extension
        issue(mem_pkg::OP_SW, 0, 32'h11223344, 0);
        issue(mem_pkg::OP_LW, 0, 0, 0);
        issue(mem_pkg::OP_SH, 4, 32'hAAAA8001, 0);
        issue(mem_pkg::OP_SH, 6, 32'h5555F00F, 0);
        issue(mem_pkg::OP_LW, 4, 0, 0);
        issue(mem_pkg::OP_SB, 8, 32'hFFFFFF81, 0);
        issue(mem_pkg::OP_SB, 9, 32'h12345602, 0);
        issue(mem_pkg::OP_SB, 10, 32'h000000C3, 0);
        issue(mem_pkg::OP_SB, 11, 32'hABCDEF74, 0);
        issue(mem_pkg::OP_LW, 8, 0, 0);
        for (int k = 0; k < 4; k++) begin
            issue(mem_pkg::OP_LB, 8 + k, 0, $urandom);
            issue(mem_pkg::OP_LBU, 8 + k, 0, $urandom);
        end
        for (int k = 0; k < 4; k += 2) begin
            issue(mem_pkg::OP_LH, 8 + k, 0, $urandom);
            issue(mem_pkg::OP_LHU, 8 + k, 0, $urandom);
        end
        issue(mem_pkg::OP_LW, 8, 0, 0);

        // unaligned left/right pairs
        for (int k = 0; k < 4; k++) begin
            issue(mem_pkg::OP_LWL, k, 0, 32'hDEADBEEF);
            issue(mem_pkg::OP_LWR, k, 0, 32'hDEADBEEF);
        end
        for (int k = 0; k < 4; k++) begin
            issue(mem_pkg::OP_SW, 12, 32'hA0B1C2D3, 0);
            issue(mem_pkg::OP_SWL, 12 + k, 32'h01234567, 0);
            issue(mem_pkg::OP_LW, 12, 0, 0);
            issue(mem_pkg::OP_SW, 12, 32'hA0B1C2D3, 0);
            issue(mem_pkg::OP_SWR, 12 + k, 32'h89ABCDEF, 0);
            issue(mem_pkg::OP_LW, 12, 0, 0);
        end

        // back to back store then load over the forwarding path
        issue(mem_pkg::OP_SW, 16, 32'hCAFEF00D, 0);
        issue(mem_pkg::OP_LW, 16, 0, 0);
        issue(mem_pkg::OP_SB, 17, 32'h0000005A, 0);
        issue(mem_pkg::OP_LH, 16, 0, 0);       // partial forward
        issue(mem_pkg::OP_SW, 20, 32'h12345678, 0);
        issue(mem_pkg::OP_LW, 16, 0, 0);       // other word, no forward
        issue(mem_pkg::OP_LW, 20, 0, 0);

        // misaligned accesses
        issue(mem_pkg::OP_SW, 1, 32'hFFFFFFFF, 0);
        issue(mem_pkg::OP_SH, 5, 32'hFFFFFFFF, 0);
        issue(mem_pkg::OP_LL, 24, 0, 0);
        issue(mem_pkg::OP_SC, 26, 32'hFFFFFFFF, 0); // keeps the link
        issue(mem_pkg::OP_LW, 3, 0, 0);
        issue(mem_pkg::OP_LH, 9, 0, 0);
        issue(mem_pkg::OP_LHU, 11, 0, 0);
        issue(mem_pkg::OP_LL, 13, 0, 0);
        issue(mem_pkg::OP_LW, 0, 0, 0);
        issue(mem_pkg::OP_LW, 4, 0, 0);
        issue(mem_pkg::OP_SC, 24, 32'h0BADCAFE, 0);
        issue(mem_pkg::OP_LW, 24, 0, 0);

        for (int n = 0; n < n_random; n++) begin
            op   = pick_op($urandom % 16);
            lane = ($urandom % 3 == 0) ? $urandom % 4 : 0;
            addr = (($urandom % 16) << 2) | lane;
            issue(op, addr, $urandom, $urandom);
        end
        issue(6'h00, 0, 0, 0);
        issue(6'h00, 0, 0, 0);

        while (es_q.size() != 0 || rd_pend) begin
            @(negedge clk);
            #1;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== mips_mem_stage.f ====
src/mem_pkg.sv
src/mem_control.sv
src/mem_pipe_regs.sv
src/data_ram.sv
src/mem_stage_top.sv
test/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mips_mem_stage

sources:
  - files:
      - src/mem_pkg.sv
      - src/mem_control.sv
      - src/mem_pipe_regs.sv
      - src/data_ram.sv
      - src/mem_stage_top.sv
  - target: test
    files:
      - test/tb_mem_stage.sv
